// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_tanimoto
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Result: pass" || (echo "Result: fail"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/tanimoto_props.sv
`timescale 1ns/1ns

module tanimoto_props #(
    parameter bit FIFO_SIDE = 1'b0
) (
    input logic clk,
    input logic rstn,
    input logic o_read,
    input logic over,
    input logic o_pair_valid,
    input logic o_pair_last,
    input logic push,
    input logic full
);
    if (FIFO_SIDE) begin : g_fifo
        a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
            else $error("FIFO pushed while full");
    end else begin : g_top
        a_last_valid: assert property (@(posedge clk) disable iff (!rstn)
            o_pair_last |-> o_pair_valid)
            else $error("o_pair_last without o_pair_valid");
        a_over_no_read: assert property (@(posedge clk) disable iff (!rstn) over |-> !o_read)
            else $error("o_read high in ST_OVER");
        // Output must be idle one cycle after any reset edge
        a_reset_idle: assert property (@(posedge clk) !rstn |=> !o_pair_valid)
            else $error("o_pair_valid high after reset");
    end
endmodule

bind tanimoto_top tanimoto_props #(.FIFO_SIDE(1'b0)) u_props (
    .clk          (clk),
    .rstn         (rstn),
    .o_read       (o_read),
    .over         (over),
    .o_pair_valid (o_pair_valid),
    .o_pair_last  (o_pair_last),
    .push         (1'b0),
    .full         (1'b0)
);

bind sync_fifo tanimoto_props #(.FIFO_SIDE(1'b1)) u_props (
    .clk          (clk),
    .rstn         (rstn),
    .o_read       (1'b0),
    .over         (1'b0),
    .o_pair_valid (1'b0),
    .o_pair_last  (1'b0),
    .push         (i_push),
    .full         (o_free == '0)
);

// File: dv/tb_tanimoto.sv
`timescale 1ns/1ns
`include "tanimoto_config.svh"

module tb_tanimoto;
    import vec_pkg::*;
    import ctrl_pkg::*;

    localparam int N_REF       = `TANI_N_REF;
    localparam int THR_N       = 2 * `TANI_VEC_W + 1;
    localparam int PAIR_N      = 1 << (2 * `TANI_ID_W);
    localparam int CYCLE_LIMIT = 20000;

    logic      clk;
    logic      rstn;
    vec_t      i_vec;
    logic      i_valid;
    logic      i_last;
    logic      o_read;
    logic      i_thr_we;
    thr_addr_t i_thr_addr;
    weight_t   i_thr_data;
    logic      o_pair_valid;
    id_pair_t  o_pair;
    logic      o_pair_last;
    logic      i_pair_read;

    int   errors;
    int   checks;
    int   cycles;
    int   thr_model [THR_N];
    bit   exp_pair [PAIR_N];
    int   exp_left;
    int   exp_total;
    int   rx_count;
    int   accepted;
    bit   last_seen;
    bit   stall_seen;
    bit   read_en;
    vec_t ref_buf [N_REF];
    vec_t qry_buf [$];

    tanimoto_top i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_vec        (i_vec),
        .i_valid      (i_valid),
        .i_last       (i_last),
        .o_read       (o_read),
        .i_thr_we     (i_thr_we),
        .i_thr_addr   (i_thr_addr),
        .i_thr_data   (i_thr_data),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair),
        .o_pair_last  (o_pair_last),
        .i_pair_read  (i_pair_read)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Output reader follows read_en one edge later
    always @(posedge clk) begin
        i_pair_read <= read_en;
    end

    // A pair seen here is consumed on the next rising edge
    always @(negedge clk) begin
        if (rstn && i_pair_read && o_pair_valid) begin
            if (o_pair_last) begin
                check("pair value with last marker", o_pair, 0);
                check("expected pairs missing at last marker", exp_left, 0);
                last_seen = 1'b1;
            end else begin
                check("received pair is in the expected set", exp_pair[o_pair], 1);
                if (exp_pair[o_pair]) begin
                    exp_pair[o_pair] = 1'b0;
                    exp_left--;
                end
                rx_count++;
            end
        end
    end

    task automatic load_table(input bit third);
        for (int s = 0; s < THR_N; s++) begin
            // Tanimoto >= 0.5 means 3*common >= weight sum
            thr_model[s] = third ? (s + 2) / 3 : 0;
            @(posedge clk);
            i_thr_we   <= 1'b1;
            i_thr_addr <= thr_addr_t'(s);
            i_thr_data <= weight_t'(thr_model[s]);
        end
        @(posedge clk);
        i_thr_we <= 1'b0;
    endtask

    task automatic build_expected();
        int s;
        int c;
        for (int p = 0; p < PAIR_N; p++) begin
            exp_pair[p] = 1'b0;
        end
        exp_left = 0;
        for (int r = 0; r < N_REF; r++) begin
            for (int q = 0; q < qry_buf.size(); q++) begin
                s = $countones(ref_buf[r]) + $countones(qry_buf[q]);
                c = $countones(ref_buf[r] & qry_buf[q]);
                if (thr_model[s] <= c) begin
                    exp_pair[{vec_id_t'(r), vec_id_t'(N_REF + q)}] = 1'b1;
                    exp_left++;
                end
            end
        end
        exp_total  = exp_left;
        rx_count   = 0;
        accepted   = 0;
        last_seen  = 1'b0;
        stall_seen = 1'b0;
    endtask

    // Called just after a rising edge, returns just after the accepting edge
    task automatic send_beat(input vec_t v, input bit last);
        bit acc;
        i_valid <= 1'b1;
        i_vec   <= v;
        i_last  <= last;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = o_read;
            if (!acc) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
        end
        accepted++;
    endtask

    task automatic send_stream();
        @(posedge clk);
        for (int r = 0; r < N_REF; r++) begin
            send_beat(ref_buf[r], 1'b0);
        end
        for (int q = 0; q < qry_buf.size(); q++) begin
            send_beat(qry_buf[q], q == qry_buf.size() - 1);
        end
        i_valid <= 1'b0;
        i_last  <= 1'b0;
    endtask

    task automatic wait_run_end();
        wait (last_seen);
        @(posedge clk);
        check("pairs received in run", rx_count, exp_total);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("o_pair_valid after reset", o_pair_valid, 0);
        check("o_pair_last after reset", o_pair_last, 0);
        check("o_read after reset", o_read, 1);
    endtask

    task automatic test_all_pass();
        load_table(1'b0);
        for (int r = 0; r < N_REF; r++) begin
            ref_buf[r] = vec_t'($urandom());
        end
        qry_buf.delete();
        for (int q = 0; q < 6; q++) begin
            qry_buf.push_back(vec_t'($urandom()));
        end
        build_expected();
        read_en = 1'b1;
        send_stream();
        wait_run_end();
        // Every reference and query pair passes a zero table
        check("pairs received with all-pass table", rx_count, 24);
    endtask

    task automatic test_screen();
        load_table(1'b1);
        // Zero reference and zero query give a pair with weight sum 0
        ref_buf[0] = '0;
        for (int r = 1; r < N_REF; r++) begin
            ref_buf[r] = vec_t'($urandom() & $urandom());
        end
        qry_buf.delete();
        qry_buf.push_back('0);
        for (int r = 0; r < N_REF; r++) begin
            qry_buf.push_back(ref_buf[r] ^ (vec_t'(1) << ($urandom() % `TANI_VEC_W)));
        end
        for (int q = 0; q < 6; q++) begin
            qry_buf.push_back(vec_t'($urandom() & $urandom()));
        end
        qry_buf.push_back(ref_buf[1]);
        build_expected();
        read_en = 1'b1;
        send_stream();
        wait_run_end();
    endtask

    task automatic test_backpressure();
        load_table(1'b0);
        for (int r = 0; r < N_REF; r++) begin
            ref_buf[r] = vec_t'($urandom());
        end
        qry_buf.delete();
        for (int q = 0; q < 30; q++) begin
            qry_buf.push_back(vec_t'($urandom()));
        end
        build_expected();
        read_en = 1'b0;
        fork
            send_stream();
            begin
                wait (stall_seen || accepted == N_REF + 30);
                check("o_read fell with queries pending", stall_seen, 1);
                check("some queries still pending at stall", accepted < N_REF + 30, 1);
                repeat (20) @(posedge clk);
                read_en = 1'b1;
            end
        join
        wait_run_end();
    endtask

    task automatic test_restart();
        // Previous run ended with the last marker, so loading starts again
        @(negedge clk);
        check("o_read after restart", o_read, 1);
        check("o_pair_valid after restart", o_pair_valid, 0);
        load_table(1'b1);
        for (int r = 0; r < N_REF; r++) begin
            ref_buf[r] = vec_t'($urandom() | $urandom());
        end
        qry_buf.delete();
        for (int q = 0; q < 8; q++) begin
            if (q % 2 == 0) begin
                qry_buf.push_back(ref_buf[q / 2] & vec_t'($urandom() | $urandom()));
            end else begin
                qry_buf.push_back(vec_t'($urandom()));
            end
        end
        build_expected();
        read_en = 1'b1;
        send_stream();
        wait_run_end();
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        errors     = 0;
        checks     = 0;
        read_en    = 1'b0;
        rstn       = 1'b0;
        i_vec      = '0;
        i_valid    = 1'b0;
        i_last     = 1'b0;
        i_thr_we   = 1'b0;
        i_thr_addr = '0;
        i_thr_data = '0;
        i_pair_read = 1'b0;
        void'($urandom(89419));
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_all_pass();
        test_screen();
        test_backpressure();
        test_restart();
        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end
endmodule

// File: hdl/ctrl_pkg.sv
`include "tanimoto_config.svh"

package ctrl_pkg;
    typedef enum logic [1:0] {
        ST_LOAD,
        ST_COMPARE,
        ST_FLUSH,
        ST_OVER
    } seq_state_t;
    // One entry per possible weight sum, 0 to 2*VEC_W
    typedef logic [$clog2(2*`TANI_VEC_W+1)-1:0] thr_addr_t;
endpackage

// File: hdl/lane_cmp.sv
`timescale 1ns/1ns
`include "tanimoto_config.svh"

module lane_cmp (
    input  logic                clk,
    input  logic                rstn,
    lane_if.downstream          i_lane,
    lane_if.upstream            o_lane,
    input  logic                i_thr_we,
    input  ctrl_pkg::thr_addr_t i_thr_addr,
    input  vec_pkg::weight_t    i_thr_data,
    output logic                o_push,
    output vec_pkg::id_pair_t   o_pair
);
    import vec_pkg::*;

    localparam int THR_N = 2 * `TANI_VEC_W + 1;

    vec_t     ref_vec;
    weight_t  ref_weight;
    vec_id_t  ref_id;
    // Stage A holds the query and also feeds the next lane
    logic     a_valid;
    vec_t     a_vec;
    weight_t  a_weight;
    vec_id_t  a_id;
    logic     b_valid;
    weight_t  b_cnt;
    wsum_t    b_wsum;
    id_pair_t b_pair;
    logic     c_valid;
    weight_t  c_thr;
    weight_t  c_cnt;
    id_pair_t c_pair;
    weight_t  and_cnt;
    weight_t  thr_mem [THR_N];

    // On a load the stored reference moves on to the next lane
    assign o_lane.ref_shift = i_lane.ref_shift;
    assign o_lane.q_valid   = a_valid;
    assign o_lane.vec       = i_lane.ref_shift ? ref_vec : a_vec;
    assign o_lane.weight    = i_lane.ref_shift ? ref_weight : a_weight;
    assign o_lane.id        = i_lane.ref_shift ? ref_id : a_id;

    always_comb begin
        and_cnt = '0;
        for (int b = 0; b < `TANI_VEC_W; b++) begin
            and_cnt = and_cnt + weight_t'(a_vec[b] & ref_vec[b]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_lane.ref_shift) begin
            ref_vec    <= i_lane.vec;
            ref_weight <= i_lane.weight;
            ref_id     <= i_lane.id;
        end
        a_vec    <= i_lane.vec;
        a_weight <= i_lane.weight;
        a_id     <= i_lane.id;
        b_cnt    <= and_cnt;
        b_wsum   <= wsum_t'(ref_weight) + wsum_t'(a_weight);
        b_pair   <= {ref_id, a_id};
        c_thr    <= thr_mem[b_wsum];
        c_cnt    <= b_cnt;
        c_pair   <= b_pair;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            a_valid <= 1'b0;
            b_valid <= 1'b0;
            c_valid <= 1'b0;
        end else begin
            a_valid <= i_lane.q_valid;
            b_valid <= a_valid;
            c_valid <= b_valid;
        end
    end

    // Local copy of the threshold table, indexed by weight sum
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < THR_N; i++) begin
                thr_mem[i] <= '0;
            end
        end else if (i_thr_we && int'(i_thr_addr) < THR_N) begin
            thr_mem[i_thr_addr] <= i_thr_data;
        end
    end

    assign o_push = c_valid && (c_thr <= c_cnt);
    assign o_pair = c_pair;
endmodule

// File: hdl/lane_if.sv
`timescale 1ns/1ns

interface lane_if;
    import vec_pkg::*;

    logic    ref_shift;
    logic    q_valid;
    vec_t    vec;
    weight_t weight;
    vec_id_t id;

    // Producer side of one link in the lane chain
    modport upstream (output ref_shift, output q_valid, output vec, output weight, output id);

    modport downstream (input ref_shift, input q_valid, input vec, input weight, input id);
endinterface

// File: hdl/match_merge.sv
`timescale 1ns/1ns
`include "tanimoto_config.svh"

module match_merge (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`TANI_N_REF-1:0] i_push,
    input  vec_pkg::id_pair_t      i_pair [`TANI_N_REF],
    input  logic                   i_over,
    input  logic                   i_pair_read,
    output logic                   o_pair_valid,
    output vec_pkg::id_pair_t      o_pair,
    output logic                   o_pair_last,
    output logic                   o_near_full,
    output logic                   o_all_empty
);
    import vec_pkg::*;

    localparam int N_LANE = `TANI_N_REF;
    localparam int LANE_W = (N_LANE > 1) ? $clog2(N_LANE) : 1;
    localparam int FREE_W = $clog2(`TANI_FIFO_DEPTH + 1);

    logic [N_LANE-1:0] empty;
    logic [N_LANE-1:0] pop;
    logic [N_LANE-1:0] near;
    id_pair_t          head [N_LANE];
    logic [FREE_W-1:0] free [N_LANE];
    logic [LANE_W-1:0] rr_q;
    logic [LANE_W-1:0] grant;
    logic              any_valid;
    logic              do_pop;

    for (genvar k = 0; k < N_LANE; k++) begin : g_fifo
        sync_fifo #(
            .DEPTH (`TANI_FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .i_push  (i_push[k]),
            .i_data  (i_pair[k]),
            .i_pop   (pop[k]),
            .o_data  (head[k]),
            .o_empty (empty[k]),
            .o_free  (free[k])
        );
        assign pop[k]  = do_pop && (grant == LANE_W'(k));
        assign near[k] = free[k] < FREE_W'(`TANI_THROTTLE_MARGIN);
    end

    // First non-empty FIFO at or after the round-robin pointer
    always_comb begin
        grant     = rr_q;
        any_valid = 1'b0;
        for (int k = N_LANE - 1; k >= 0; k--) begin
            if (!empty[(int'(rr_q) + k) % N_LANE]) begin
                grant     = LANE_W'((int'(rr_q) + k) % N_LANE);
                any_valid = 1'b1;
            end
        end
    end

    assign do_pop = i_pair_read && !i_over && any_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rr_q <= '0;
        end else if (do_pop) begin
            rr_q <= (int'(grant) == N_LANE - 1) ? '0 : grant + 1'b1;
        end
    end

    // End of run shows as a valid zero pair with the last flag
    assign o_pair_valid = i_over || any_valid;
    assign o_pair_last  = i_over;
    assign o_pair       = i_over ? '0 : head[grant];
    assign o_near_full  = |near;
    assign o_all_empty  = &empty;
endmodule

// File: hdl/popcount.sv
`timescale 1ns/1ns
`include "tanimoto_config.svh"

module popcount (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_valid,
    input  logic             i_load,
    input  vec_pkg::vec_t    i_vec,
    input  vec_pkg::vec_id_t i_id,
    lane_if.upstream         o_lane
);
    import vec_pkg::*;

    // First stage counts per byte, second stage adds the bytes
    localparam int GRP_W = 8;
    localparam int N_GRP = (`TANI_VEC_W + GRP_W - 1) / GRP_W;

    weight_t part_d [N_GRP];
    weight_t part_q [N_GRP];
    weight_t sum_d;
    vec_t    vec_q;
    vec_id_t id_q;
    logic    valid_q;
    logic    load_q;

    always_comb begin
        for (int g = 0; g < N_GRP; g++) begin
            part_d[g] = '0;
            for (int b = g * GRP_W; b < (g + 1) * GRP_W && b < `TANI_VEC_W; b++) begin
                part_d[g] = part_d[g] + weight_t'(i_vec[b]);
            end
        end
    end

    always_comb begin
        sum_d = '0;
        for (int g = 0; g < N_GRP; g++) begin
            sum_d = sum_d + part_q[g];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q          <= 1'b0;
            load_q           <= 1'b0;
            o_lane.ref_shift <= 1'b0;
            o_lane.q_valid   <= 1'b0;
        end else begin
            valid_q          <= i_valid;
            load_q           <= i_load;
            o_lane.ref_shift <= valid_q && load_q;
            o_lane.q_valid   <= valid_q && !load_q;
        end
    end

    // Vector and ID travel alongside the adder tree
    always_ff @(posedge clk) begin
        part_q        <= part_d;
        vec_q         <= i_vec;
        id_q          <= i_id;
        o_lane.vec    <= vec_q;
        o_lane.weight <= sum_d;
        o_lane.id     <= id_q;
    end
endmodule

// File: hdl/seq_ctrl.sv
`timescale 1ns/1ns
`include "tanimoto_config.svh"

module seq_ctrl (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_valid,
    input  logic             i_last,
    output logic             o_read,
    output logic             o_accept,
    output logic             o_load,
    output vec_pkg::vec_id_t o_id,
    input  logic             i_near_full,
    input  logic             i_all_empty,
    output logic             o_over,
    input  logic             i_pair_read
);
    import vec_pkg::*;
    import ctrl_pkg::*;

    // Covers the popcount latency, the lane chain and the compare stages
    localparam int DRAIN   = `TANI_POP_LAT + `TANI_N_REF + 4;
    localparam int DRAIN_W = $clog2(DRAIN + 1);

    seq_state_t         state_q;
    vec_id_t            id_q;
    logic [DRAIN_W-1:0] drain_q;

    assign o_read   = (state_q == ST_LOAD || state_q == ST_COMPARE) && !i_near_full;
    assign o_accept = i_valid && o_read;
    assign o_load   = state_q == ST_LOAD;
    assign o_over   = state_q == ST_OVER;
    assign o_id     = id_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= ST_LOAD;
            id_q    <= '0;
            drain_q <= '0;
        end else begin
            // ID is the stream position of each accepted beat
            if (o_accept) begin
                id_q <= id_q + 1'b1;
            end
            case (state_q)
                ST_LOAD: begin
                    if (o_accept && id_q == vec_id_t'(`TANI_N_REF - 1)) begin
                        state_q <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (o_accept && i_last) begin
                        state_q <= ST_FLUSH;
                        drain_q <= DRAIN_W'(DRAIN);
                    end
                end
                ST_FLUSH: begin
                    if (drain_q != '0) begin
                        drain_q <= drain_q - 1'b1;
                    end else if (i_all_empty) begin
                        state_q <= ST_OVER;
                    end
                end
                ST_OVER: begin
                    // Reading the last marker starts a new run
                    if (i_pair_read) begin
                        state_q <= ST_LOAD;
                        id_q    <= '0;
                    end
                end
            endcase
        end
    end
endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       i_push,
    input  vec_pkg::id_pair_t          i_data,
    input  logic                       i_pop,
    output vec_pkg::id_pair_t          o_data,
    output logic                       o_empty,
    output logic [$clog2(DEPTH+1)-1:0] o_free
);
    import vec_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    id_pair_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Wraps explicitly so depths other than powers of two work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = i_push && (count_q != CNT_W'(DEPTH));
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Head word is visible without a read strobe
    assign o_data  = mem[rd_ptr];
    assign o_empty = count_q == '0;
    assign o_free  = CNT_W'(DEPTH) - count_q;
endmodule

// File: hdl/tanimoto_config.svh
`ifndef TANIMOTO_CONFIG_SVH
`define TANIMOTO_CONFIG_SVH

// Fingerprint width, one bus word
`define TANI_VEC_W 32
// References held, one lane each
`define TANI_N_REF 4
`define TANI_ID_W 8
// Cycles from an accepted beat to lane 0
`define TANI_POP_LAT 2
`define TANI_FIFO_DEPTH 16
// Input stops when a lane FIFO has fewer free entries than this
`define TANI_THROTTLE_MARGIN 10

`endif

// File: hdl/tanimoto_top.sv
`timescale 1ns/1ns
`include "tanimoto_config.svh"

module tanimoto_top (
    input  logic                clk,
    input  logic                rstn,
    input  vec_pkg::vec_t       i_vec,
    input  logic                i_valid,
    input  logic                i_last,
    output logic                o_read,
    input  logic                i_thr_we,
    input  ctrl_pkg::thr_addr_t i_thr_addr,
    input  vec_pkg::weight_t    i_thr_data,
    output logic                o_pair_valid,
    output vec_pkg::id_pair_t   o_pair,
    output logic                o_pair_last,
    input  logic                i_pair_read
);
    import vec_pkg::*;

    logic                   accept;
    logic                   load;
    logic                   over;
    logic                   near_full;
    logic                   all_empty;
    vec_id_t                beat_id;
    logic [`TANI_N_REF-1:0] lane_push;
    id_pair_t               lane_pair [`TANI_N_REF];

    // Link k feeds lane k, the last link leaves the chain
    lane_if lane [`TANI_N_REF+1] ();

    seq_ctrl u_seq (
        .clk         (clk),
        .rstn        (rstn),
        .i_valid     (i_valid),
        .i_last      (i_last),
        .o_read      (o_read),
        .o_accept    (accept),
        .o_load      (load),
        .o_id        (beat_id),
        .i_near_full (near_full),
        .i_all_empty (all_empty),
        .o_over      (over),
        .i_pair_read (i_pair_read)
    );

    popcount u_pop (
        .clk     (clk),
        .rstn    (rstn),
        .i_valid (accept),
        .i_load  (load),
        .i_vec   (i_vec),
        .i_id    (beat_id),
        .o_lane  (lane[0])
    );

    for (genvar k = 0; k < `TANI_N_REF; k++) begin : g_lane
        lane_cmp u_lane (
            .clk        (clk),
            .rstn       (rstn),
            .i_lane     (lane[k]),
            .o_lane     (lane[k+1]),
            .i_thr_we   (i_thr_we),
            .i_thr_addr (i_thr_addr),
            .i_thr_data (i_thr_data),
            .o_push     (lane_push[k]),
            .o_pair     (lane_pair[k])
        );
    end

    match_merge u_merge (
        .clk          (clk),
        .rstn         (rstn),
        .i_push       (lane_push),
        .i_pair       (lane_pair),
        .i_over       (over),
        .i_pair_read  (i_pair_read),
        .o_pair_valid (o_pair_valid),
        .o_pair       (o_pair),
        .o_pair_last  (o_pair_last),
        .o_near_full  (near_full),
        .o_all_empty  (all_empty)
    );
endmodule

// File: hdl/vec_pkg.sv
`include "tanimoto_config.svh"

package vec_pkg;
    typedef logic [`TANI_VEC_W-1:0] vec_t;
    // Must hold a count of VEC_W set bits
    typedef logic [$clog2(`TANI_VEC_W+1)-1:0] weight_t;
    typedef logic [$clog2(`TANI_VEC_W+1):0] wsum_t;
    typedef logic [`TANI_ID_W-1:0] vec_id_t;
    // Reference ID in the upper half, query ID in the lower half
    typedef logic [2*`TANI_ID_W-1:0] id_pair_t;
endpackage

// File: vlog.f
+incdir+hdl
hdl/vec_pkg.sv
hdl/ctrl_pkg.sv
hdl/lane_if.sv
hdl/popcount.sv
hdl/seq_ctrl.sv
hdl/lane_cmp.sv
hdl/sync_fifo.sv
hdl/match_merge.sv
hdl/tanimoto_top.sv
dv/tanimoto_props.sv
dv/tb_tanimoto.sv
